/* source/dataflow_pkg.sv */
package dataflow_pkg;

    // token payload width unless the top level overrides it
    parameter int data_width_default = 32;

    // join state of the two-input token mux
    //   idle  waiting for the select token and the side it names
    //   done  output token offered until the consumer takes it
    typedef enum logic {
        idle = 1'b0,
        done = 1'b1
    } mux_state_e;

endpackage

/* source/alu_pkg.sv */
package alu_pkg;

    // width of the opcode field on the op channel
    parameter int op_width = 2;

    // opcode carried with every op token
    typedef enum logic [op_width-1:0] {
        op_add  = 2'd0,
        op_sub  = 2'd1,
        op_xor  = 2'd2,
        op_pass = 2'd3
    } alu_op_e;

    // printable rule name for messages
    function automatic string op_name(alu_op_e op);
        case (op)
            op_add:  return "add";
            op_sub:  return "sub";
            op_xor:  return "xor";
            default: return "pass";
        endcase
    endfunction

endpackage

/* source/token_mux2.sv */
`timescale 1ns/100ps

module token_mux2 #(
    parameter int data_width = dataflow_pkg::data_width_default
) (
    input  logic                  clk,
    input  logic                  rst,
    // a channel
    input  logic [data_width-1:0] a_data,
    input  logic                  a_valid,
    output logic                  a_ready,
    // b channel
    input  logic [data_width-1:0] b_data,
    input  logic                  b_valid,
    output logic                  b_ready,
    // select channel where 0 picks a and 1 picks b
    input  logic                  sel,
    input  logic                  sel_valid,
    output logic                  sel_ready,
    // joined output channel
    output logic [data_width-1:0] mux_data,
    output logic                  mux_valid,
    input  logic                  mux_ready
);

    dataflow_pkg::mux_state_e state;

    logic [data_width-1:0] a_buf;
    logic [data_width-1:0] b_buf;
    logic                  sel_buf;
    logic                  a_full;
    logic                  b_full;
    logic                  sel_full;
    logic                  chosen_full;
    logic                  mux_fire;

    // one-token buffers ready only while empty
    assign a_ready   = !a_full;
    assign b_ready   = !b_full;
    assign sel_ready = !sel_full;

    // the buffered select decides which side is joined
    assign chosen_full = sel_buf ? b_full : a_full;
    assign mux_valid   = (state == dataflow_pkg::done);
    assign mux_data    = sel_buf ? b_buf : a_buf;
    assign mux_fire    = mux_valid && mux_ready;

    // payload captures
    always_ff @(posedge clk) begin
        if (a_valid && !a_full) begin
            a_buf <= a_data;
        end
        if (b_valid && !b_full) begin
            b_buf <= b_data;
        end
        if (sel_valid && !sel_full) begin
            sel_buf <= sel;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= dataflow_pkg::idle;
            a_full   <= 1'b0;
            b_full   <= 1'b0;
            sel_full <= 1'b0;
        end else begin
            if (a_valid && !a_full) begin
                a_full <= 1'b1;
            end else if (mux_fire && !sel_buf) begin
                a_full <= 1'b0;
            end

            if (b_valid && !b_full) begin
                b_full <= 1'b1;
            end else if (mux_fire && sel_buf) begin
                b_full <= 1'b0;
            end

            // select stays full while the output token is offered
            if (sel_valid && !sel_full) begin
                sel_full <= 1'b1;
            end else if (mux_fire) begin
                sel_full <= 1'b0;
            end

            case (state)
                dataflow_pkg::idle: begin
                    if (sel_full && chosen_full) begin
                        state <= dataflow_pkg::done;
                    end
                end
                default: begin
                    // unused side keeps its token for a later select
                    if (mux_ready) begin
                        state <= dataflow_pkg::idle;
                    end
                end
            endcase
        end
    end

    a_join_held : assert property (@(posedge clk) disable iff (rst)
        mux_valid |-> sel_full && chosen_full);

    a_data_stable : assert property (@(posedge clk) disable iff (rst)
        mux_valid && !mux_ready |=> $stable(mux_data) && mux_valid);

endmodule

/* source/token_alu.sv */
`timescale 1ns/100ps

module token_alu #(
    parameter int data_width = dataflow_pkg::data_width_default
) (
    input  logic                  clk,
    input  logic                  rst,
    // data token from the mux
    input  logic [data_width-1:0] mux_data,
    input  logic                  mux_valid,
    output logic                  mux_ready,
    // opcode token
    input  alu_pkg::alu_op_e      op_code,
    input  logic [data_width-1:0] op_operand,
    input  logic                  op_valid,
    output logic                  op_ready,
    // registered result
    output logic [data_width-1:0] alu_data,
    output logic                  alu_valid,
    input  logic                  alu_ready
);

    logic                  slot_free;
    logic                  d_held;
    logic                  o_held;
    logic [data_width-1:0] d_hold;
    logic [data_width-1:0] o_hold;
    alu_pkg::alu_op_e      c_hold;
    logic                  d_take;
    logic                  o_take;
    logic                  d_avail;
    logic                  o_avail;
    logic                  load;
    logic [data_width-1:0] d_val;
    logic [data_width-1:0] o_val;
    alu_pkg::alu_op_e      c_val;
    logic [data_width-1:0] result;

    // result register empty or draining this cycle
    assign slot_free = !alu_valid || alu_ready;

    // a side that arrived alone waits in its hold register
    assign mux_ready = slot_free && !d_held;
    assign op_ready  = slot_free && !o_held;

    assign d_take  = mux_valid && mux_ready;
    assign o_take  = op_valid && op_ready;
    assign d_avail = d_held || d_take;
    assign o_avail = o_held || o_take;
    assign load    = d_avail && o_avail && slot_free;

    assign d_val = d_held ? d_hold : mux_data;
    assign o_val = o_held ? o_hold : op_operand;
    assign c_val = o_held ? c_hold : op_code;

    always_comb begin
        case (c_val)
            alu_pkg::op_add: result = d_val + o_val;
            alu_pkg::op_sub: result = d_val - o_val;
            alu_pkg::op_xor: result = d_val ^ o_val;
            default:         result = d_val;
        endcase
    end

    always_ff @(posedge clk) begin
        if (d_take && !load) begin
            d_hold <= mux_data;
        end
        if (o_take && !load) begin
            o_hold <= op_operand;
            c_hold <= op_code;
        end
        if (load) begin
            alu_data <= result;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            d_held    <= 1'b0;
            o_held    <= 1'b0;
            alu_valid <= 1'b0;
        end else begin
            d_held <= load ? 1'b0 : d_avail;
            o_held <= load ? 1'b0 : o_avail;
            if (load) begin
                alu_valid <= 1'b1;
            end else if (alu_ready) begin
                alu_valid <= 1'b0;
            end
        end
    end

    a_result_hold : assert property (@(posedge clk) disable iff (rst)
        alu_valid && !alu_ready |=> $stable(alu_data) && alu_valid);

endmodule

/* source/token_fifo.sv */
`timescale 1ns/100ps

module token_fifo #(
    parameter int data_width = dataflow_pkg::data_width_default,
    parameter int fifo_depth = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [data_width-1:0] in_data,
    input  logic                  in_valid,
    output logic                  in_ready,
    output logic [data_width-1:0] out_data,
    output logic                  out_valid,
    input  logic                  out_ready
);

    localparam int ptr_width = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_width = $clog2(fifo_depth + 1);
    localparam logic [ptr_width-1:0] last_slot = ptr_width'(fifo_depth - 1);

    logic [data_width-1:0] mem [fifo_depth];
    logic [ptr_width-1:0]  wr_ptr;
    logic [ptr_width-1:0]  rd_ptr;
    logic [cnt_width-1:0]  count;
    logic                  push;
    logic                  pop;

    assign in_ready  = (count != cnt_width'(fifo_depth));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap at the last slot so any depth works
            if (push) begin
                wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_bound : assert property (@(posedge clk) disable iff (rst)
        count <= cnt_width'(fifo_depth));

    // equal pointers mean empty unless the count says full
    a_no_empty_pop : assert property (@(posedge clk) disable iff (rst)
        pop |-> (rd_ptr != wr_ptr) || (count == cnt_width'(fifo_depth)));

endmodule

/* source/dataflow_select_alu.sv */
`timescale 1ns/100ps

module dataflow_select_alu #(
    parameter int data_width = dataflow_pkg::data_width_default,
    parameter int fifo_depth = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [data_width-1:0] a_data,
    input  logic                  a_valid,
    output logic                  a_ready,
    input  logic [data_width-1:0] b_data,
    input  logic                  b_valid,
    output logic                  b_ready,
    input  logic                  sel,
    input  logic                  sel_valid,
    output logic                  sel_ready,
    input  alu_pkg::alu_op_e      op_code,
    input  logic [data_width-1:0] op_operand,
    input  logic                  op_valid,
    output logic                  op_ready,
    output logic [data_width-1:0] out_data,
    output logic                  out_valid,
    input  logic                  out_ready
);

    // mux to operator node
    logic [data_width-1:0] mux_data;
    logic                  mux_valid;
    logic                  mux_ready;

    // operator node to output fifo
    logic [data_width-1:0] alu_data;
    logic                  alu_valid;
    logic                  alu_ready;

    token_mux2 #(
        .data_width(data_width)
    ) u_mux (
        .clk       (clk),
        .rst       (rst),
        .a_data    (a_data),
        .a_valid   (a_valid),
        .a_ready   (a_ready),
        .b_data    (b_data),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .sel       (sel),
        .sel_valid (sel_valid),
        .sel_ready (sel_ready),
        .mux_data  (mux_data),
        .mux_valid (mux_valid),
        .mux_ready (mux_ready)
    );

    token_alu #(
        .data_width(data_width)
    ) u_alu (
        .clk        (clk),
        .rst        (rst),
        .mux_data   (mux_data),
        .mux_valid  (mux_valid),
        .mux_ready  (mux_ready),
        .op_code    (op_code),
        .op_operand (op_operand),
        .op_valid   (op_valid),
        .op_ready   (op_ready),
        .alu_data   (alu_data),
        .alu_valid  (alu_valid),
        .alu_ready  (alu_ready)
    );

    token_fifo #(
        .data_width(data_width),
        .fifo_depth(fifo_depth)
    ) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_data   (alu_data),
        .in_valid  (alu_valid),
        .in_ready  (alu_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

/* dv/dataflow_select_alu_tb.sv */
`timescale 1ns/100ps

module dataflow_select_alu_tb;

    localparam int data_width = dataflow_pkg::data_width_default;
    localparam int fifo_depth = 4;

    logic                  clk = 1'b0;
    logic                  rst;
    logic [data_width-1:0] a_data;
    logic                  a_valid;
    logic                  a_ready;
    logic [data_width-1:0] b_data;
    logic                  b_valid;
    logic                  b_ready;
    logic                  sel;
    logic                  sel_valid;
    logic                  sel_ready;
    alu_pkg::alu_op_e      op_code;
    logic [data_width-1:0] op_operand;
    logic                  op_valid;
    logic                  op_ready;
    logic [data_width-1:0] out_data;
    logic                  out_valid;
    logic                  out_ready;

    // token streams taken from the pattern file
    logic [data_width-1:0] a_q[$];
    logic [data_width-1:0] b_q[$];
    logic                  sel_q[$];
    alu_pkg::alu_op_e      op_q[$];
    logic [data_width-1:0] opd_q[$];
    logic [data_width-1:0] exp_q[$];
    alu_pkg::alu_op_e      res_op_q[$];
    int                    n_patterns = 0;
    logic                  loaded = 1'b0;

    dataflow_select_alu #(
        .data_width(data_width),
        .fifo_depth(fifo_depth)
    ) u_dataflow_select_alu (
        .clk        (clk),
        .rst        (rst),
        .a_data     (a_data),
        .a_valid    (a_valid),
        .a_ready    (a_ready),
        .b_data     (b_data),
        .b_valid    (b_valid),
        .b_ready    (b_ready),
        .sel        (sel),
        .sel_valid  (sel_valid),
        .sel_ready  (sel_ready),
        .op_code    (op_code),
        .op_operand (op_operand),
        .op_valid   (op_valid),
        .op_ready   (op_ready),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

    always #2 clk = ~clk;

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic load_patterns();
        int          fd;
        string       line;
        logic [31:0] f_aen;
        logic [31:0] f_a;
        logic [31:0] f_ben;
        logic [31:0] f_b;
        logic [31:0] f_sel;
        logic [31:0] f_op;
        logic [31:0] f_opd;
        logic [31:0] f_exp;
        fd = $fopen("dv/select_alu_patterns.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open pattern file dv/select_alu_patterns.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // skip comment and blank lines
                if (line.len() > 0 && line[0] != "#") begin
                    if ($sscanf(line, "%h %h %h %h %h %h %h %h", f_aen, f_a, f_ben, f_b,
                                f_sel, f_op, f_opd, f_exp) == 8) begin
                        if (f_aen[0]) a_q.push_back(f_a);
                        if (f_ben[0]) b_q.push_back(f_b);
                        sel_q.push_back(f_sel[0]);
                        op_q.push_back(alu_pkg::alu_op_e'(f_op[1:0]));
                        res_op_q.push_back(alu_pkg::alu_op_e'(f_op[1:0]));
                        opd_q.push_back(f_opd);
                        exp_q.push_back(f_exp);
                        n_patterns++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // producers drive on the falling edge
    task automatic drive_a();
        while (a_q.size() > 0) begin
            repeat ($urandom_range(2)) @(negedge clk);
            a_data  = a_q.pop_front();
            a_valid = 1'b1;
            // ready is registered so its value now holds at the next rising edge
            while (!a_ready) @(negedge clk);
            @(negedge clk);
            a_valid = 1'b0;
        end
    endtask

    task automatic drive_b();
        while (b_q.size() > 0) begin
            repeat ($urandom_range(2)) @(negedge clk);
            b_data  = b_q.pop_front();
            b_valid = 1'b1;
            while (!b_ready) @(negedge clk);
            @(negedge clk);
            b_valid = 1'b0;
        end
    endtask

    task automatic drive_sel();
        while (sel_q.size() > 0) begin
            repeat ($urandom_range(2)) @(negedge clk);
            sel       = sel_q.pop_front();
            sel_valid = 1'b1;
            while (!sel_ready) @(negedge clk);
            @(negedge clk);
            sel_valid = 1'b0;
        end
    endtask

    task automatic drive_op();
        while (op_q.size() > 0) begin
            repeat ($urandom_range(2)) @(negedge clk);
            op_code    = op_q.pop_front();
            op_operand = opd_q.pop_front();
            op_valid   = 1'b1;
            while (!op_ready) @(negedge clk);
            @(negedge clk);
            op_valid = 1'b0;
        end
    endtask

    // random back-pressure with results compared in pattern order
    task automatic collect_results();
        logic [data_width-1:0] expv;
        logic [data_width-1:0] held_data;
        logic                  held;
        alu_pkg::alu_op_e      resop;
        int                    idx;
        held = 1'b0;
        idx  = 0;
        while (exp_q.size() > 0) begin
            @(negedge clk);
            if (held) begin
                assert (out_valid && out_data === held_data)
                    else report_failure($sformatf("FAIL %0t ns: stalled output moved, %h -> %h",
                                                  $time, held_data, out_data));
            end
            out_ready = ($urandom_range(3) != 0);
            held      = out_valid && !out_ready;
            held_data = out_data;
            if (out_valid && out_ready) begin
                expv  = exp_q.pop_front();
                resop = res_op_q.pop_front();
                assert (out_data === expv)
                    else report_failure($sformatf("FAIL %0t ns: result %0d (%s) expected %h got %h",
                                                  $time, idx, alu_pkg::op_name(resop),
                                                  expv, out_data));
                idx++;
            end
        end
        // the last pop happens on the next rising edge
        @(negedge clk);
        out_ready = 1'b0;
    endtask

    initial begin
        void'($urandom(70));
        rst        = 1'b1;
        a_data     = '0;
        a_valid    = 1'b0;
        b_data     = '0;
        b_valid    = 1'b0;
        sel        = 1'b0;
        sel_valid  = 1'b0;
        op_code    = alu_pkg::op_add;
        op_operand = '0;
        op_valid   = 1'b0;
        out_ready  = 1'b0;
        load_patterns();
        assert (n_patterns > 0)
            else report_failure("pattern file holds no transactions");
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        assert (!out_valid && a_ready && b_ready && sel_ready && op_ready)
            else report_failure("reset fault: out_valid high or an input ready low after reset");
        fork
            drive_a();
            drive_b();
            drive_sel();
            drive_op();
            collect_results();
        join
        // nothing more may come out
        repeat (20) @(negedge clk);
        assert (!out_valid) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            report_failure("an extra result appeared after all expected results");
        end
    end

    // watchdog sized from the pattern count
    initial begin
        wait (loaded);
        #(n_patterns * 40 * 4);
        report_failure("timeout: results still missing when the watchdog expired");
    end

endmodule

/* dv/select_alu_patterns.txt */
# a_en a_data b_en b_data sel op operand expected, all hex, data ignored when its enable is 0
# op 0 add, 1 sub, 2 xor, 3 pass; a select takes the oldest unconsumed token of its side
1 00000005 0 00000000 0 0 00000003 00000008
0 00000000 1 00000010 1 1 00000001 0000000f
1 000000ff 1 00000020 0 2 0000000f 000000f0
0 00000000 0 00000000 1 0 00000002 00000022
1 ffffffff 0 00000000 0 0 00000001 00000000
0 00000000 1 00000000 1 1 00000001 ffffffff
1 12345678 0 00000000 0 2 ffffffff edcba987
0 00000000 1 deadbeef 1 3 00000000 deadbeef
1 a5a5a5a5 1 0000abcd 1 3 ffffffff 0000abcd
1 00000001 0 00000000 0 0 7fffffff 25a5a5a4
0 00000000 0 00000000 0 1 00000002 ffffffff
1 80000000 1 00000003 1 1 00000005 fffffffe
0 00000000 1 00000007 0 0 80000000 00000000
0 00000000 0 00000000 1 2 00000007 00000000
1 0000ffff 0 00000000 0 2 00000000 0000ffff
1 00000100 1 00000200 0 3 12345678 00000100
1 00000300 1 00000400 1 0 00000001 00000201
0 00000000 0 00000000 0 1 00000300 00000000
0 00000000 0 00000000 1 1 00000401 ffffffff
1 cafef00d 0 00000000 0 2 cafef00d 00000000
0 00000000 1 fffffffe 1 0 00000003 00000001
1 00000042 0 00000000 0 3 ffffffff 00000042
0 00000000 1 13579bdf 1 2 02468ace 11111111
1 00000009 1 00000006 0 1 00000006 00000003
0 00000000 0 00000000 1 0 fffffffa 00000000

/* dataflow_select_alu.f */
source/dataflow_pkg.sv
source/alu_pkg.sv
source/token_mux2.sv
source/token_alu.sv
source/token_fifo.sv
source/dataflow_select_alu.sv
dv/dataflow_select_alu_tb.sv

/* Bender.yml */
package:
  name: dataflow_select_alu

sources:
  - files:
      - source/dataflow_pkg.sv
      - source/alu_pkg.sv
      - source/token_mux2.sv
      - source/token_alu.sv
      - source/token_fifo.sv
      - source/dataflow_select_alu.sv
  - target: simulation
    files:
      - dv/dataflow_select_alu_tb.sv
